/* dec_pkg.sv */
// shared decode definitions: opcodes, operation classes, instruction views
// and entry widths

package dec_pkg;

  // data and address width
  localparam int XLEN = 32;

  // ------------------------------------------------------------------------
  // major opcodes of the decoded RV32I subset
  // ------------------------------------------------------------------------
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_OP     = 7'b0110011;

  // only word loads and stores are accepted
  localparam logic [2:0] FUNCT3_LW = 3'b010;
  localparam logic [2:0] FUNCT3_SW = 3'b010;

  // operation class handed to issue
  typedef enum logic [3:0] {
    OP_ALU,
    OP_ALU_IMM,
    OP_LOAD,
    OP_STORE,
    OP_BRANCH,
    OP_JAL,
    OP_JALR,
    OP_LUI,
    OP_ILLEGAL
  } op_class_e;

  // ------------------------------------------------------------------------
  // one instruction word seen through its formats
  // ------------------------------------------------------------------------
  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_fmt_t;

  typedef struct packed {
    logic [6:0] imm_hi;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm_lo;
    logic [6:0] opcode;
  } s_fmt_t;

  typedef struct packed {
    logic       imm12;
    logic [5:0] imm10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm4_1;
    logic       imm11;
    logic [6:0] opcode;
  } b_fmt_t;

  typedef union packed {
    r_fmt_t r_fmt;
    i_fmt_t i_fmt;
    s_fmt_t s_fmt;
    b_fmt_t b_fmt;
  } instr_u;

endpackage

/* fetch_buffer.sv */
// circular FIFO of fetch entries (pc and instruction word) with flush
`timescale 1ns/10ps

module fetch_buffer #(
  parameter int FETCH_DEPTH = 4
) (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     flush_i,
  input  logic                     push_i,
  input  logic [dec_pkg::XLEN-1:0] push_pc_i,
  input  logic [31:0]              push_instr_i,
  input  logic                     pop_i,
  output logic                     full_o,
  output logic                     empty_o,
  output logic [dec_pkg::XLEN-1:0] head_pc_o,
  output logic [31:0]              head_instr_o
);

  // depth is expected to be a power of two
  localparam int AW = $clog2(FETCH_DEPTH);

  logic [dec_pkg::XLEN-1:0] pc_mem    [FETCH_DEPTH];
  logic [31:0]              instr_mem [FETCH_DEPTH];

  // pointers carry one wrap bit above the index
  logic [AW:0] wr_ptr_q;
  logic [AW:0] rd_ptr_q;
  logic        push_en;
  logic        pop_en;

  assign empty_o = (wr_ptr_q == rd_ptr_q);
  assign full_o  = (wr_ptr_q[AW] != rd_ptr_q[AW]) &&
                   (wr_ptr_q[AW-1:0] == rd_ptr_q[AW-1:0]);

  // refuse pushes when full or flushing
  assign push_en = push_i && !full_o && !flush_i;
  assign pop_en  = pop_i && !empty_o;

  assign head_pc_o    = pc_mem[rd_ptr_q[AW-1:0]];
  assign head_instr_o = instr_mem[rd_ptr_q[AW-1:0]];

  // pointers
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
    end else if (flush_i) begin
      // drop every queued entry
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
    end else begin
      if (push_en) wr_ptr_q <= wr_ptr_q + 1'b1;
      if (pop_en) rd_ptr_q <= rd_ptr_q + 1'b1;
    end
  end

  // storage
  always_ff @(posedge clk_i) begin
    if (push_en) begin
      pc_mem[wr_ptr_q[AW-1:0]]    <= push_pc_i;
      instr_mem[wr_ptr_q[AW-1:0]] <= push_instr_i;
    end
  end

endmodule

/* rvc_expander.sv */
// compressed instruction expander for C.ADDI, C.LI, C.MV, C.ADD, C.J, C.BEQZ
`timescale 1ns/10ps

module rvc_expander (
  input  logic [31:0] instr_i,
  output logic [31:0] instr_o,
  output logic        is_compressed_o,
  output logic        illegal_o
);

  logic [15:0] c;

  assign c = instr_i[15:0];

  // a full-width word always ends in 11
  assign is_compressed_o = (instr_i[1:0] != 2'b11);

  always_comb begin
    instr_o   = instr_i;
    illegal_o = 1'b0;

    if (is_compressed_o) begin
      // quadrant in [1:0], funct3 in [15:13]
      case ({c[1:0], c[15:13]})
        // ------------------------------------------------------------------
        // quadrant 1
        // ------------------------------------------------------------------
        5'b01_000: begin
          // c.addi -> addi rd, rd, imm
          instr_o = {{6{c[12]}}, c[12], c[6:2], c[11:7], 3'b000, c[11:7],
                     dec_pkg::OPC_OP_IMM};
        end
        5'b01_010: begin
          // c.li -> addi rd, x0, imm
          instr_o = {{6{c[12]}}, c[12], c[6:2], 5'd0, 3'b000, c[11:7],
                     dec_pkg::OPC_OP_IMM};
        end
        5'b01_101: begin
          // c.j -> jal x0, offset
          // jal immediate order is [20|10:1|11|19:12]
          instr_o = {c[12], c[8], c[10:9], c[6], c[7], c[2], c[11], c[5:3],
                     c[12], {8{c[12]}}, 5'd0, dec_pkg::OPC_JAL};
        end
        5'b01_110: begin
          // c.beqz -> beq rs1', x0, offset
          // rs1' is the 3-bit field offset by 8
          instr_o = {c[12], {3{c[12]}}, c[6:5], c[2], 5'd0, 2'b01, c[9:7],
                     3'b000, c[11:10], c[4:3], c[12], dec_pkg::OPC_BRANCH};
        end
        // ------------------------------------------------------------------
        // quadrant 2
        // ------------------------------------------------------------------
        5'b10_100: begin
          // rs2 of zero selects c.jr, c.jalr, c.ebreak, none supported here
          if (c[6:2] == 5'd0) begin
            illegal_o = 1'b1;
          end else if (!c[12]) begin
            // c.mv -> add rd, x0, rs2
            instr_o = {7'd0, c[6:2], 5'd0, 3'b000, c[11:7], dec_pkg::OPC_OP};
          end else begin
            // c.add -> add rd, rd, rs2
            instr_o = {7'd0, c[6:2], c[11:7], 3'b000, c[11:7], dec_pkg::OPC_OP};
          end
        end
        default: begin
          illegal_o = 1'b1;
        end
      endcase
    end
  end

endmodule

/* instr_decoder.sv */
// RV32I subset decoder with the registered ID/issue entry fields
`timescale 1ns/10ps

module instr_decoder (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     load_i,
  input  logic [dec_pkg::XLEN-1:0] pc_i,
  input  logic [31:0]              instr_i,
  input  logic                     is_compressed_i,
  input  logic                     illegal_i,
  output dec_pkg::op_class_e       op_class_o,
  output logic [4:0]               rd_o,
  output logic [4:0]               rs1_o,
  output logic [4:0]               rs2_o,
  output logic [dec_pkg::XLEN-1:0] imm_o,
  output logic [dec_pkg::XLEN-1:0] pc_o,
  output logic                     is_compressed_o,
  output logic                     is_ctrl_flow_o,
  output logic                     illegal_o
);

  dec_pkg::instr_u          iw;
  dec_pkg::op_class_e       op_d;
  logic [4:0]               rd_d;
  logic [4:0]               rs1_d;
  logic [4:0]               rs2_d;
  logic [dec_pkg::XLEN-1:0] imm_d;
  logic                     ctrl_d;
  logic                     ill_d;

  assign iw = instr_i;

  // ------------------------------------------------------------------------
  // combinational decode
  // ------------------------------------------------------------------------
  always_comb begin
    op_d   = dec_pkg::OP_ILLEGAL;
    rd_d   = iw.r_fmt.rd;
    rs1_d  = iw.r_fmt.rs1;
    rs2_d  = iw.r_fmt.rs2;
    imm_d  = '0;
    ctrl_d = 1'b0;

    case (iw.r_fmt.opcode)
      dec_pkg::OPC_LUI: begin
        op_d  = dec_pkg::OP_LUI;
        rs1_d = '0;
        rs2_d = '0;
        imm_d = {instr_i[31:12], 12'd0};
      end
      dec_pkg::OPC_JAL: begin
        op_d   = dec_pkg::OP_JAL;
        rs1_d  = '0;
        rs2_d  = '0;
        ctrl_d = 1'b1;
        imm_d  = {{12{instr_i[31]}}, instr_i[19:12], instr_i[20], instr_i[30:21], 1'b0};
      end
      dec_pkg::OPC_JALR: begin
        if (iw.i_fmt.funct3 == 3'b000) op_d = dec_pkg::OP_JALR;
        rs2_d  = '0;
        ctrl_d = 1'b1;
        imm_d  = {{20{iw.i_fmt.imm[11]}}, iw.i_fmt.imm};
      end
      dec_pkg::OPC_BRANCH: begin
        // funct3 010 and 011 are unassigned
        if (iw.b_fmt.funct3[2:1] != 2'b01) op_d = dec_pkg::OP_BRANCH;
        rd_d   = '0;
        ctrl_d = 1'b1;
        imm_d  = {{19{iw.b_fmt.imm12}}, iw.b_fmt.imm12, iw.b_fmt.imm11,
                  iw.b_fmt.imm10_5, iw.b_fmt.imm4_1, 1'b0};
      end
      dec_pkg::OPC_LOAD: begin
        if (iw.i_fmt.funct3 == dec_pkg::FUNCT3_LW) op_d = dec_pkg::OP_LOAD;
        rs2_d = '0;
        imm_d = {{20{iw.i_fmt.imm[11]}}, iw.i_fmt.imm};
      end
      dec_pkg::OPC_STORE: begin
        if (iw.s_fmt.funct3 == dec_pkg::FUNCT3_SW) op_d = dec_pkg::OP_STORE;
        rd_d  = '0;
        imm_d = {{20{iw.s_fmt.imm_hi[6]}}, iw.s_fmt.imm_hi, iw.s_fmt.imm_lo};
      end
      dec_pkg::OPC_OP_IMM: begin
        // shifts constrain the upper immediate bits
        case (iw.i_fmt.funct3)
          3'b001: if (iw.i_fmt.imm[11:5] == 7'd0) op_d = dec_pkg::OP_ALU_IMM;
          3'b101: begin
            if (iw.i_fmt.imm[11:5] == 7'd0 || iw.i_fmt.imm[11:5] == 7'b0100000) begin
              op_d = dec_pkg::OP_ALU_IMM;
            end
          end
          default: op_d = dec_pkg::OP_ALU_IMM;
        endcase
        rs2_d = '0;
        imm_d = {{20{iw.i_fmt.imm[11]}}, iw.i_fmt.imm};
      end
      dec_pkg::OPC_OP: begin
        // funct7 0100000 only for sub and sra
        if (iw.r_fmt.funct7 == 7'd0) begin
          op_d = dec_pkg::OP_ALU;
        end else if (iw.r_fmt.funct7 == 7'b0100000 &&
                     (iw.r_fmt.funct3 == 3'b000 || iw.r_fmt.funct3 == 3'b101)) begin
          op_d = dec_pkg::OP_ALU;
        end
      end
      default: ;
    endcase

    // expander rejects override everything
    if (illegal_i) op_d = dec_pkg::OP_ILLEGAL;
    ill_d = (op_d == dec_pkg::OP_ILLEGAL);

    if (ill_d) begin
      rd_d   = '0;
      rs1_d  = '0;
      rs2_d  = '0;
      imm_d  = '0;
      ctrl_d = 1'b0;
    end
  end

  // ------------------------------------------------------------------------
  // ID/issue register, valid flag lives in the control block
  // ------------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      op_class_o      <= dec_pkg::OP_ALU;
      rd_o            <= '0;
      rs1_o           <= '0;
      rs2_o           <= '0;
      imm_o           <= '0;
      pc_o            <= '0;
      is_compressed_o <= 1'b0;
      is_ctrl_flow_o  <= 1'b0;
      illegal_o       <= 1'b0;
    end else if (load_i) begin
      op_class_o      <= op_d;
      rd_o            <= rd_d;
      rs1_o           <= rs1_d;
      rs2_o           <= rs2_d;
      imm_o           <= imm_d;
      pc_o            <= pc_i;
      is_compressed_o <= is_compressed_i;
      is_ctrl_flow_o  <= ctrl_d;
      illegal_o       <= ill_d;
    end
  end

endmodule

/* decode_ctrl.sv */
// buffer pop, register load and issue valid control
`timescale 1ns/10ps

module decode_ctrl (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic flush_i,
  input  logic buf_empty_i,
  input  logic issue_ack_i,
  output logic buf_pop_o,
  output logic id_load_o,
  output logic issue_valid_o
);

  logic valid_q;
  logic valid_d;

  // ------------------------------------------------------------------------
  // load enable
  // ------------------------------------------------------------------------
  // register has room when empty or being acknowledged this cycle
  assign id_load_o = !buf_empty_i && !flush_i && (!valid_q || issue_ack_i);

  // head moves into the register, so pop in the same cycle
  assign buf_pop_o = id_load_o;

  // ------------------------------------------------------------------------
  // issue valid flop
  // ------------------------------------------------------------------------
  always_comb begin
    valid_d = valid_q;
    // taken by issue
    if (issue_ack_i) valid_d = 1'b0;
    // reload wins over the acknowledge
    if (id_load_o) valid_d = 1'b1;
    // flush wins over everything
    if (flush_i) valid_d = 1'b0;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= valid_d;
    end
  end

  assign issue_valid_o = valid_q;

endmodule

/* decode_top.sv */
// decode subsystem top: fetch buffer, expander, decoder and control
`timescale 1ns/10ps

module decode_top #(
  parameter int FETCH_DEPTH = 4
) (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     flush_i,
  // fetch side
  input  logic                     fetch_valid_i,
  input  logic [dec_pkg::XLEN-1:0] fetch_pc_i,
  input  logic [31:0]              fetch_instr_i,
  output logic                     fetch_ready_o,
  // issue side
  output logic                     issue_valid_o,
  input  logic                     issue_ack_i,
  output dec_pkg::op_class_e       issue_op_o,
  output logic [4:0]               issue_rd_o,
  output logic [4:0]               issue_rs1_o,
  output logic [4:0]               issue_rs2_o,
  output logic [dec_pkg::XLEN-1:0] issue_imm_o,
  output logic [dec_pkg::XLEN-1:0] issue_pc_o,
  output logic                     issue_compressed_o,
  output logic                     issue_ctrl_flow_o,
  output logic                     issue_illegal_o
);

  logic                     buf_full;
  logic                     buf_empty;
  logic                     buf_pop;
  logic [dec_pkg::XLEN-1:0] buf_pc;
  logic [31:0]              buf_instr;
  logic                     id_load;
  logic [31:0]              exp_instr;
  logic                     exp_compressed;
  logic                     exp_illegal;

  // no new fetch while flushing
  assign fetch_ready_o = !buf_full && !flush_i;

  fetch_buffer #(
    .FETCH_DEPTH (FETCH_DEPTH)
  ) fetch_buffer_inst (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .flush_i      (flush_i),
    .push_i       (fetch_valid_i),
    .push_pc_i    (fetch_pc_i),
    .push_instr_i (fetch_instr_i),
    .pop_i        (buf_pop),
    .full_o       (buf_full),
    .empty_o      (buf_empty),
    .head_pc_o    (buf_pc),
    .head_instr_o (buf_instr)
  );

  // expansion works on the buffer head
  rvc_expander rvc_expander_inst (
    .instr_i         (buf_instr),
    .instr_o         (exp_instr),
    .is_compressed_o (exp_compressed),
    .illegal_o       (exp_illegal)
  );

  instr_decoder instr_decoder_inst (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .load_i          (id_load),
    .pc_i            (buf_pc),
    .instr_i         (exp_instr),
    .is_compressed_i (exp_compressed),
    .illegal_i       (exp_illegal),
    .op_class_o      (issue_op_o),
    .rd_o            (issue_rd_o),
    .rs1_o           (issue_rs1_o),
    .rs2_o           (issue_rs2_o),
    .imm_o           (issue_imm_o),
    .pc_o            (issue_pc_o),
    .is_compressed_o (issue_compressed_o),
    .is_ctrl_flow_o  (issue_ctrl_flow_o),
    .illegal_o       (issue_illegal_o)
  );

  decode_ctrl decode_ctrl_inst (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .flush_i       (flush_i),
    .buf_empty_i   (buf_empty),
    .issue_ack_i   (issue_ack_i),
    .buf_pop_o     (buf_pop),
    .id_load_o     (id_load),
    .issue_valid_o (issue_valid_o)
  );

endmodule

/* decode_props.sv */
// handshake, fetch ready and flush assertions bound into the decode top level
`timescale 1ns/10ps

module decode_props #(
  parameter int FETCH_DEPTH = 4
) (
  input logic        clk_i,
  input logic        rst_ni,
  input logic        flush_i,
  input logic        fetch_valid_i,
  input logic        issue_ack_i,
  input logic        valid_i,
  input logic        ready_i,
  input logic        pop_i,
  input logic [3:0]  op_i,
  input logic [4:0]  rd_i,
  input logic [4:0]  rs1_i,
  input logic [4:0]  rs2_i,
  input logic [31:0] imm_i,
  input logic [31:0] pc_i,
  input logic [2:0]  flags_i
);

  // number of failed assertions
  int assert_fails = 0;

  // buffer occupancy rebuilt from the fetch and pop handshakes
  logic [$clog2(FETCH_DEPTH):0] occ_q;
  logic                         push;

  assign push = fetch_valid_i && ready_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      occ_q <= '0;
    end else if (flush_i) begin
      occ_q <= '0;
    end else if (push && !pop_i) begin
      occ_q <= occ_q + 1'b1;
    end else if (pop_i && !push) begin
      occ_q <= occ_q - 1'b1;
    end
  end

  // held entry stays put until taken or flushed
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    valid_i && !issue_ack_i && !flush_i |=>
      valid_i && $stable({op_i, rd_i, rs1_i, rs2_i, imm_i, pc_i, flags_i}))
    else begin
      assert_fails++;
      $error("issue entry changed while waiting for acknowledge");
    end

  // fetch is refused exactly when the buffer is full or a flush is on
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    ready_i == (!flush_i && occ_q < FETCH_DEPTH))
    else begin
      assert_fails++;
      $error("fetch ready does not match the buffer occupancy");
    end

  assert property (@(posedge clk_i) disable iff (!rst_ni) flush_i |=> !valid_i)
    else begin
      assert_fails++;
      $error("issue valid after a flush");
    end

endmodule

bind decode_top decode_props #(
  .FETCH_DEPTH (FETCH_DEPTH)
) decode_props_inst (
  .clk_i         (clk_i),
  .rst_ni        (rst_ni),
  .flush_i       (flush_i),
  .fetch_valid_i (fetch_valid_i),
  .issue_ack_i   (issue_ack_i),
  .valid_i       (issue_valid_o),
  .ready_i       (fetch_ready_o),
  .pop_i         (buf_pop),
  .op_i          (issue_op_o),
  .rd_i          (issue_rd_o),
  .rs1_i         (issue_rs1_o),
  .rs2_i         (issue_rs2_o),
  .imm_i         (issue_imm_o),
  .pc_i          (issue_pc_o),
  .flags_i       ({issue_compressed_o, issue_ctrl_flow_o, issue_illegal_o})
);

/* decode_tb.sv */
// decode subsystem testbench with stimulus, reference decode, compare process
// and watchdog
`timescale 1ns/10ps

module decode_tb;

  // total fetched entries over all tests sets the watchdog limit
  localparam int N_INSTR = 177;

  logic        clk_i;
  logic        rst_ni;
  logic        flush_i;
  logic        fetch_valid_i;
  logic [31:0] fetch_pc_i;
  logic [31:0] fetch_instr_i;
  logic        fetch_ready_o;
  logic        issue_valid_o;
  logic        issue_ack_i;
  dec_pkg::op_class_e issue_op_o;
  logic [4:0]  issue_rd_o;
  logic [4:0]  issue_rs1_o;
  logic [4:0]  issue_rs2_o;
  logic [31:0] issue_imm_o;
  logic [31:0] issue_pc_o;
  logic        issue_compressed_o;
  logic        issue_ctrl_flow_o;
  logic        issue_illegal_o;

  // expected entries as {pc, op, rd, rs1, rs2, imm, compressed, ctrl, illegal}
  logic [85:0] exp_q[$];
  logic [31:0] seed = 32'h354;
  logic [31:0] ill_words [10];
  int          errors = 0;
  int          pass_cnt = 0;
  int          fail_cnt = 0;
  int          start_err;
  logic [31:0] pc_cnt = 32'h1000;
  logic        ack_rand = 1'b0;
  logic        vld_rand = 1'b0;
  logic        ack_en = 1'b1;

  decode_top #(
    .FETCH_DEPTH (4)
  ) decode_top_inst (
    .clk_i              (clk_i),
    .rst_ni             (rst_ni),
    .flush_i            (flush_i),
    .fetch_valid_i      (fetch_valid_i),
    .fetch_pc_i         (fetch_pc_i),
    .fetch_instr_i      (fetch_instr_i),
    .fetch_ready_o      (fetch_ready_o),
    .issue_valid_o      (issue_valid_o),
    .issue_ack_i        (issue_ack_i),
    .issue_op_o         (issue_op_o),
    .issue_rd_o         (issue_rd_o),
    .issue_rs1_o        (issue_rs1_o),
    .issue_rs2_o        (issue_rs2_o),
    .issue_imm_o        (issue_imm_o),
    .issue_pc_o         (issue_pc_o),
    .issue_compressed_o (issue_compressed_o),
    .issue_ctrl_flow_o  (issue_ctrl_flow_o),
    .issue_illegal_o    (issue_illegal_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  function automatic logic [31:0] next_rand();
    seed = seed ^ (seed << 13);
    seed = seed ^ (seed >> 17);
    seed = seed ^ (seed << 5);
    return seed;
  endfunction

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  // ------------------------------------------------------------------------
  // reference decode straight from the RV32I and RVC encodings
  // ------------------------------------------------------------------------
  function automatic logic [53:0] decode_ref(input logic [31:0] w);
    dec_pkg::op_class_e op;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [31:0] imm;
    logic [15:0] c;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic        comp;
    logic        ctrl;
    logic        ill;
    c    = w[15:0];
    f3   = w[14:12];
    f7   = w[31:25];
    comp = (w[1:0] != 2'b11);
    op   = dec_pkg::OP_ILLEGAL;
    rd   = w[11:7];
    rs1  = w[19:15];
    rs2  = w[24:20];
    imm  = '0;
    if (comp) begin
      // fields taken from the compressed layout directly
      rs2 = '0;
      case ({c[1:0], c[15:13]})
        5'b01_000, 5'b01_010: begin
          op  = dec_pkg::OP_ALU_IMM;
          rd  = c[11:7];
          rs1 = c[14] ? 5'd0 : c[11:7];
          imm = {{26{c[12]}}, c[12], c[6:2]};
        end
        5'b01_101: begin
          op  = dec_pkg::OP_JAL;
          rd  = '0;
          rs1 = '0;
          imm = {{20{c[12]}}, c[12], c[8], c[10:9], c[6], c[7], c[2], c[11], c[5:3], 1'b0};
        end
        5'b01_110: begin
          op  = dec_pkg::OP_BRANCH;
          rd  = '0;
          rs1 = {2'b01, c[9:7]};
          imm = {{23{c[12]}}, c[12], c[6:5], c[2], c[11:10], c[4:3], 1'b0};
        end
        5'b10_100: begin
          // zero rs2 would be a jump register form
          if (c[6:2] != 5'd0) op = dec_pkg::OP_ALU;
          rd  = c[11:7];
          rs1 = c[12] ? c[11:7] : 5'd0;
          rs2 = c[6:2];
        end
        default: ;
      endcase
    end else begin
      case (w[6:0])
        dec_pkg::OPC_LUI: begin
          op  = dec_pkg::OP_LUI;
          rs1 = '0;
          rs2 = '0;
          imm = {w[31:12], 12'd0};
        end
        dec_pkg::OPC_JAL: begin
          op  = dec_pkg::OP_JAL;
          rs1 = '0;
          rs2 = '0;
          imm = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
        end
        dec_pkg::OPC_JALR: begin
          if (f3 == 3'b000) op = dec_pkg::OP_JALR;
          rs2 = '0;
          imm = {{20{w[31]}}, w[31:20]};
        end
        dec_pkg::OPC_BRANCH: begin
          if (f3 != 3'b010 && f3 != 3'b011) op = dec_pkg::OP_BRANCH;
          rd  = '0;
          imm = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
        end
        dec_pkg::OPC_LOAD: begin
          if (f3 == 3'b010) op = dec_pkg::OP_LOAD;
          rs2 = '0;
          imm = {{20{w[31]}}, w[31:20]};
        end
        dec_pkg::OPC_STORE: begin
          if (f3 == 3'b010) op = dec_pkg::OP_STORE;
          rd  = '0;
          imm = {{21{w[31]}}, w[30:25], w[11:7]};
        end
        dec_pkg::OPC_OP_IMM: begin
          // slli needs zero upper bits, srli/srai allow bit 30
          if ((f3 != 3'b001 && f3 != 3'b101) || f7 == 7'd0 ||
              (f3 == 3'b101 && f7 == 7'b0100000)) op = dec_pkg::OP_ALU_IMM;
          rs2 = '0;
          imm = {{20{w[31]}}, w[31:20]};
        end
        dec_pkg::OPC_OP: begin
          if (f7 == 7'd0 || (f7 == 7'b0100000 && (f3 == 3'b000 || f3 == 3'b101)))
            op = dec_pkg::OP_ALU;
        end
        default: ;
      endcase
    end
    ill  = (op == dec_pkg::OP_ILLEGAL);
    ctrl = (op == dec_pkg::OP_BRANCH || op == dec_pkg::OP_JAL || op == dec_pkg::OP_JALR);
    if (ill) begin
      rd  = '0;
      rs1 = '0;
      rs2 = '0;
      imm = '0;
    end
    return {op, rd, rs1, rs2, imm, comp, ctrl, ill};
  endfunction

  // per-class templates with kinds 0..7 full width and 8..13 compressed
  function automatic logic [31:0] gen_instr(input int kind);
    logic [31:0] r;
    logic [31:0] w;
    r = next_rand();
    case (kind)
      0: w = {r[31:7], dec_pkg::OPC_LUI};
      1: w = {r[31:7], dec_pkg::OPC_JAL};
      2: w = {r[31:15], 3'b000, r[11:7], dec_pkg::OPC_JALR};
      3: w = {r[31:15], r[14], r[14] & r[13], r[12], r[11:7], dec_pkg::OPC_BRANCH};
      4: w = {r[31:15], dec_pkg::FUNCT3_LW, r[11:7], dec_pkg::OPC_LOAD};
      5: w = {r[31:15], dec_pkg::FUNCT3_SW, r[11:7], dec_pkg::OPC_STORE};
      6: begin
        w = {r[31:7], dec_pkg::OPC_OP_IMM};
        if (r[13:12] == 2'b01) w[31:25] = {1'b0, r[30] & r[14], 5'd0};
      end
      7: begin
        w = {7'd0, r[24:7], dec_pkg::OPC_OP};
        w[30] = r[30] && (r[14:12] == 3'b000 || r[14:12] == 3'b101);
      end
      8:  w = {r[31:16], 3'b000, r[12:2], 2'b01};
      9:  w = {r[31:16], 3'b010, r[12:2], 2'b01};
      10: w = {r[31:16], 3'b101, r[12:2], 2'b01};
      11: w = {r[31:16], 3'b110, r[12:2], 2'b01};
      12: w = {r[31:16], 3'b100, 1'b0, r[11:7], r[6:2] | 5'd1, 2'b10};
      default: w = {r[31:16], 3'b100, 1'b1, r[11:7], r[6:2] | 5'd1, 2'b10};
    endcase
    return w;
  endfunction

  // offer one entry until fetch takes it
  task automatic send(input logic [31:0] instr);
    logic [31:0] rnd;
    logic        done;
    done = 1'b0;
    while (!done) begin
      @(posedge clk_i);
      #2;
      rnd           = next_rand();
      issue_ack_i   = ack_rand ? rnd[0] : ack_en;
      fetch_valid_i = vld_rand ? rnd[1] : 1'b1;
      fetch_pc_i    = pc_cnt;
      fetch_instr_i = instr;
      @(negedge clk_i);
      done = fetch_valid_i && fetch_ready_o;
    end
    pc_cnt = pc_cnt + 32'd4;
  endtask

  // queue is looked at only after an edge so the last accepted entry is in it
  task automatic drain();
    logic [31:0] rnd;
    do begin
      @(posedge clk_i);
      #2;
      rnd           = next_rand();
      fetch_valid_i = 1'b0;
      issue_ack_i   = ack_rand ? rnd[0] : ack_en;
    end while (exp_q.size() != 0);
    @(posedge clk_i);
    #2;
    fetch_valid_i = 1'b0;
    issue_ack_i   = 1'b0;
  endtask

  task automatic finish_test(input string name);
    drain();
    if (errors == start_err) begin
      pass_cnt++;
      $display("test %s: passed", name);
    end else begin
      fail_cnt++;
      $display("test %s: failed with %0d errors", name, errors - start_err);
    end
  endtask

  // ------------------------------------------------------------------------
  // compare process sampled mid-cycle where everything is settled
  // ------------------------------------------------------------------------
  always @(negedge clk_i) begin
    logic [85:0] e;
    if (flush_i) begin
      exp_q.delete();
    end else begin
      if (issue_valid_o && issue_ack_i) begin
        if (exp_q.size() == 0) begin
          errors++;
          $display("issue handshake at %0t with no entry expected", $time);
        end else begin
          e = exp_q.pop_front();
          check("issue_pc_o", issue_pc_o, e[85:54]);
          check("issue_op_o", issue_op_o, e[53:50]);
          check("issue_rd_o", issue_rd_o, e[49:45]);
          check("issue_rs1_o", issue_rs1_o, e[44:40]);
          check("issue_rs2_o", issue_rs2_o, e[39:35]);
          check("issue_imm_o", issue_imm_o, e[34:3]);
          check("issue_compressed_o", issue_compressed_o, e[2]);
          check("issue_ctrl_flow_o", issue_ctrl_flow_o, e[1]);
          check("issue_illegal_o", issue_illegal_o, e[0]);
        end
      end
      if (fetch_valid_i && fetch_ready_o) exp_q.push_back({fetch_pc_i, decode_ref(fetch_instr_i)});
    end
  end

  // watchdog allows 40 cycles per fetched entry
  initial begin
    #(N_INSTR * 40 * 40);
    $display("timeout: the tests did not finish in time");
    $display("STATUS: FAIL");
    $finish;
  end

  initial begin
    // unsupported compressed forms followed by bad opcodes or funct fields
    ill_words = '{32'h0000_0000, 32'h0000_8082, 32'h0000_4108, 32'h0000_E001,
                  32'h0000_000F, 32'h0000_8083, 32'h0000_2063, 32'h4000_1013,
                  32'h0200_0033, 32'h0000_1023};
    rst_ni        = 1'b0;
    flush_i       = 1'b0;
    fetch_valid_i = 1'b0;
    fetch_pc_i    = '0;
    fetch_instr_i = '0;
    issue_ack_i   = 1'b0;
    repeat (2) @(posedge clk_i);
    #2;
    rst_ni = 1'b1;

    start_err = errors;
    check("issue_valid_o", issue_valid_o, 1'b0);
    check("fetch_ready_o", fetch_ready_o, 1'b1);
    finish_test("reset");

    start_err = errors;
    for (int i = 0; i < 40; i++) send(gen_instr(i % 8));
    finish_test("uncompressed decode");

    start_err = errors;
    for (int i = 0; i < 36; i++) send(gen_instr(8 + i % 6));
    finish_test("compressed expansion");

    start_err = errors;
    for (int i = 0; i < 10; i++) send(ill_words[i]);
    finish_test("illegal encodings");

    // random stalls on both sides
    start_err = errors;
    ack_rand  = 1'b1;
    vld_rand  = 1'b1;
    for (int i = 0; i < 80; i++) send(gen_instr(next_rand() % 14));
    finish_test("back-pressure");

    // three entries parked behind a stalled issue port and then flushed
    start_err = errors;
    ack_rand  = 1'b0;
    vld_rand  = 1'b0;
    ack_en    = 1'b0;
    repeat (3) send(gen_instr(next_rand() % 14));
    @(posedge clk_i);
    #2;
    fetch_instr_i = gen_instr(0);
    fetch_valid_i = 1'b1;
    flush_i       = 1'b1;
    @(posedge clk_i);
    #2;
    flush_i       = 1'b0;
    fetch_valid_i = 1'b0;
    check("issue_valid_o", issue_valid_o, 1'b0);
    ack_en = 1'b1;
    repeat (8) send(gen_instr(next_rand() % 14));
    finish_test("flush");

    // failed bound assertions count against the run
    errors += decode_top_inst.decode_props_inst.assert_fails;
    $display("tests passed: %0d, failed: %0d, errors: %0d", pass_cnt, fail_cnt, errors);
    if (fail_cnt == 0 && errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

/* decode_top.f */
dec_pkg.sv
fetch_buffer.sv
rvc_expander.sv
instr_decoder.sv
decode_ctrl.sv
decode_top.sv
decode_props.sv
decode_tb.sv

/* Bender.yml */
package:
  name: decode_top

sources:
  - dec_pkg.sv
  - fetch_buffer.sv
  - rvc_expander.sv
  - instr_decoder.sv
  - decode_ctrl.sv
  - decode_top.sv
  - target: test
    files:
      - decode_props.sv
      - decode_tb.sv
